// File: rtl/wl_consts.svh
`ifndef WL_CONSTS_SVH
`define WL_CONSTS_SVH

// Word width of the weight image
`define WL_DATA_W       8

// Layer sizes
`define WL_FEAT_IN      8
`define WL_FEAT_OUT     4
`define WL_FEAT_FINAL   3

// Segment sizes in words
`define WL_W1_WORDS     (`WL_FEAT_IN * `WL_FEAT_OUT)
`define WL_A1_WORDS     (2 * `WL_FEAT_OUT)
`define WL_W2_WORDS     (`WL_FEAT_OUT * `WL_FEAT_FINAL)
`define WL_A2_WORDS     (2 * `WL_FEAT_FINAL)

`define WL_TOTAL_WORDS  (`WL_W1_WORDS + `WL_A1_WORDS + `WL_W2_WORDS + `WL_A2_WORDS)

// Segments are packed back to back, first layer weights start at zero
`define WL_A1_BASE      (`WL_W1_WORDS)
`define WL_W2_BASE      (`WL_A1_BASE + `WL_A1_WORDS)
`define WL_A2_BASE      (`WL_W2_BASE + `WL_W2_WORDS)

`endif

// File: rtl/wl_pkg.sv
`include "wl_consts.svh"

package wl_pkg;

  // One word of the flat weight image
  typedef logic [`WL_DATA_W-1:0] data_t;

  // Address into the weight image
  typedef logic [$clog2(`WL_TOTAL_WORDS)-1:0] word_addr_t;

  // Row inside one first-layer bank
  typedef logic [$clog2(`WL_FEAT_IN)-1:0] bank_row_t;

  // Offset within a segment, sized for the first-layer weights
  typedef logic [$clog2(`WL_W1_WORDS)-1:0] seg_idx_t;

  // Destination of the word currently in flight
  typedef enum logic [2:0] {
    SEG_W1,
    SEG_A1,
    SEG_W2,
    SEG_A2,
    SEG_DONE
  } seg_e;

endpackage

// File: rtl/wgt_fetch_seq.sv
`timescale 1ns/10ps
`include "wl_consts.svh"

module wgt_fetch_seq (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               sched_vld_i,
  output logic               sched_rdy_o,
  output wl_pkg::word_addr_t wgt_addr_o,
  input  wl_pkg::data_t      wgt_data_i,
  output wl_pkg::data_t      wr_data_o,
  output wl_pkg::seg_idx_t   wr_idx_o,
  output logic               w1_we_o,
  output logic               a1_we_o,
  output logic               w2_we_o,
  output logic               a2_we_o
);

  import wl_pkg::*;

  localparam int unsigned LAST_ADDR = `WL_TOTAL_WORDS - 1;

  // Addresses issued so far, stops at the word total
  word_addr_t issue_cnt_q;
  word_addr_t addr_q;
  logic       issued_q;
  logic       issue;

  seg_e       seg;
  seg_idx_t   seg_off;
  seg_e       tag_q;
  seg_idx_t   off_q;

  logic       last_wr_q;
  logic       rdy_q;

  assign issue = sched_vld_i && (issue_cnt_q < `WL_TOTAL_WORDS);

  // Address only moves on valid cycles and holds at the last word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_cnt_q <= '0;
      addr_q      <= '0;
      issued_q    <= 1'b0;
    end else begin
      issued_q <= issue;
      if (issue) begin
        addr_q      <= issue_cnt_q;
        issue_cnt_q <= issue_cnt_q + 1'b1;
      end
    end
  end

  assign wgt_addr_o = addr_q;

  // Segment decode of the address on the bus
  always_comb begin
    seg     = SEG_DONE;
    seg_off = '0;
    if (issued_q) begin
      if (addr_q < `WL_A1_BASE) begin
        seg     = SEG_W1;
        seg_off = seg_idx_t'(addr_q);
      end else if (addr_q < `WL_W2_BASE) begin
        seg     = SEG_A1;
        seg_off = seg_idx_t'(addr_q - `WL_A1_BASE);
      end else if (addr_q < `WL_A2_BASE) begin
        seg     = SEG_W2;
        seg_off = seg_idx_t'(addr_q - `WL_W2_BASE);
      end else begin
        seg     = SEG_A2;
        seg_off = seg_idx_t'(addr_q - `WL_A2_BASE);
      end
    end
  end

  // Tag follows the address by one stage to meet the memory latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_q <= SEG_DONE;
      off_q <= '0;
    end else begin
      tag_q <= seg;
      off_q <= seg_off;
    end
  end

  // Returned word lines up with the delayed tag
  assign wr_data_o = wgt_data_i;
  assign wr_idx_o  = off_q;

  assign w1_we_o = (tag_q == SEG_W1);
  assign a1_we_o = (tag_q == SEG_A1);
  assign w2_we_o = (tag_q == SEG_W2);
  assign a2_we_o = (tag_q == SEG_A2);

  // Ready goes up one cycle after the final write and stays up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_wr_q <= 1'b0;
      rdy_q     <= 1'b0;
    end else begin
      last_wr_q <= a2_we_o && (off_q == seg_idx_t'(`WL_A2_WORDS - 1));
      rdy_q     <= rdy_q | last_wr_q;
    end
  end

  assign sched_rdy_o = rdy_q;

  // Only one loader may take the shared bus in a cycle
  a_we_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({w1_we_o, a1_we_o, w2_we_o, a2_we_o}));

  // Counter saturation keeps the address inside the image
  a_addr_range : assert property (@(posedge clk) disable iff (!rst_n)
    addr_q <= LAST_ADDR);

endmodule

// File: rtl/conv1_wgt_banks.sv
`timescale 1ns/10ps
`include "wl_consts.svh"

module conv1_wgt_banks (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 we_i,
  input  wl_pkg::seg_idx_t                     idx_i,
  input  wl_pkg::data_t                        data_i,
  input  wl_pkg::bank_row_t [`WL_FEAT_OUT-1:0] rd_addr_i,
  output wl_pkg::data_t     [`WL_FEAT_OUT-1:0] rd_data_o
);

  import wl_pkg::*;

  localparam int BANK_W = $clog2(`WL_FEAT_OUT);

  logic [BANK_W-1:0] wr_bank;
  bank_row_t         wr_row;

  // Row-major layout so consecutive words land in consecutive banks
  assign wr_bank = BANK_W'(idx_i % `WL_FEAT_OUT);
  assign wr_row  = bank_row_t'(idx_i / `WL_FEAT_OUT);

  for (genvar b = 0; b < `WL_FEAT_OUT; b++) begin : g_bank
    data_t mem [`WL_FEAT_IN];
    data_t rd_q;

    always_ff @(posedge clk) begin
      if (we_i && (wr_bank == b)) begin
        mem[wr_row] <= data_i;
      end
    end

    // Registered read, one cycle from address to data
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        rd_q <= '0;
      end else begin
        rd_q <= mem[rd_addr_i[b]];
      end
    end

    assign rd_data_o[b] = rd_q;
  end

  // Sequencer must only strobe offsets of the first-layer segment
  a_idx_range : assert property (@(posedge clk) disable iff (!rst_n)
    we_i |-> (idx_i < `WL_W1_WORDS));

endmodule

// File: rtl/attn_vec_reg.sv
`timescale 1ns/10ps

module attn_vec_reg #(
  parameter int DEPTH = 8
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           we_i,
  input  wl_pkg::seg_idx_t               idx_i,
  input  wl_pkg::data_t                  data_i,
  output wl_pkg::data_t [DEPTH-1:0]      vec_o
);

  // Entry k of the vector comes from word k of its segment
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vec_o <= '0;
    end else if (we_i) begin
      vec_o[idx_i] <= data_i;
    end
  end

  // Offset from the sequencer has to fit this vector
  a_idx_range : assert property (@(posedge clk) disable iff (!rst_n)
    we_i |-> (idx_i < DEPTH));

endmodule

// File: rtl/conv2_wgt_reg.sv
`timescale 1ns/10ps
`include "wl_consts.svh"

module conv2_wgt_reg (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  we_i,
  input  wl_pkg::seg_idx_t                                      idx_i,
  input  wl_pkg::data_t                                         data_i,
  output wl_pkg::data_t [`WL_FEAT_FINAL-1:0][`WL_FEAT_OUT-1:0]  wgt_o
);

  localparam int CLS_W = $clog2(`WL_FEAT_FINAL);
  localparam int HID_W = $clog2(`WL_FEAT_OUT);

  logic [CLS_W-1:0] cls;
  logic [HID_W-1:0] hid;

  // Class index runs fastest through the segment
  assign cls = CLS_W'(idx_i % `WL_FEAT_FINAL);
  assign hid = HID_W'(idx_i / `WL_FEAT_FINAL);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wgt_o <= '0;
    end else if (we_i) begin
      wgt_o[cls][hid] <= data_i;
    end
  end

endmodule

// File: rtl/gat_wgt_loader.sv
`timescale 1ns/10ps
`include "wl_consts.svh"

module gat_wgt_loader (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  sched_vld_i,
  output logic                                                  sched_rdy_o,
  output wl_pkg::word_addr_t                                    wgt_addr_o,
  input  wl_pkg::data_t                                         wgt_data_i,
  input  wl_pkg::bank_row_t [`WL_FEAT_OUT-1:0]                  mult_wgt_addr_i,
  output wl_pkg::data_t     [`WL_FEAT_OUT-1:0]                  mult_wgt_dout_o,
  output wl_pkg::data_t     [`WL_A1_WORDS-1:0]                  a_conv1_o,
  output wl_pkg::data_t     [`WL_FEAT_FINAL-1:0][`WL_FEAT_OUT-1:0] wgt_o,
  output wl_pkg::data_t     [`WL_A2_WORDS-1:0]                  a_conv2_o
);

  import wl_pkg::*;

  // Shared write bus from the sequencer to the four loaders
  data_t    wr_data;
  seg_idx_t wr_idx;
  logic     w1_we;
  logic     a1_we;
  logic     w2_we;
  logic     a2_we;

  wgt_fetch_seq u_wgt_fetch_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .sched_vld_i (sched_vld_i),
    .sched_rdy_o (sched_rdy_o),
    .wgt_addr_o  (wgt_addr_o),
    .wgt_data_i  (wgt_data_i),
    .wr_data_o   (wr_data),
    .wr_idx_o    (wr_idx),
    .w1_we_o     (w1_we),
    .a1_we_o     (a1_we),
    .w2_we_o     (w2_we),
    .a2_we_o     (a2_we)
  );

  conv1_wgt_banks u_conv1_wgt_banks (
    .clk       (clk),
    .rst_n     (rst_n),
    .we_i      (w1_we),
    .idx_i     (wr_idx),
    .data_i    (wr_data),
    .rd_addr_i (mult_wgt_addr_i),
    .rd_data_o (mult_wgt_dout_o)
  );

  attn_vec_reg #(
    .DEPTH (`WL_A1_WORDS)
  ) u_attn_conv1 (
    .clk    (clk),
    .rst_n  (rst_n),
    .we_i   (a1_we),
    .idx_i  (wr_idx),
    .data_i (wr_data),
    .vec_o  (a_conv1_o)
  );

  conv2_wgt_reg u_conv2_wgt_reg (
    .clk    (clk),
    .rst_n  (rst_n),
    .we_i   (w2_we),
    .idx_i  (wr_idx),
    .data_i (wr_data),
    .wgt_o  (wgt_o)
  );

  attn_vec_reg #(
    .DEPTH (`WL_A2_WORDS)
  ) u_attn_conv2 (
    .clk    (clk),
    .rst_n  (rst_n),
    .we_i   (a2_we),
    .idx_i  (wr_idx),
    .data_i (wr_data),
    .vec_o  (a_conv2_o)
  );

endmodule

// File: verif/wgt_mem_model.sv
`timescale 1ns/10ps
`include "wl_consts.svh"

module wgt_mem_model (
  input  logic               clk,
  input  logic               load_we_i,
  input  wl_pkg::word_addr_t load_addr_i,
  input  wl_pkg::data_t      load_data_i,
  input  wl_pkg::word_addr_t rd_addr_i,
  output wl_pkg::data_t      rd_data_o
);

  import wl_pkg::*;

  data_t mem [`WL_TOTAL_WORDS];

  // Load port for the image, read data one cycle after the address
  always_ff @(posedge clk) begin
    if (load_we_i) begin
      mem[load_addr_i] <= load_data_i;
    end
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

// File: verif/tb_gat_wgt_loader.sv
`timescale 1ns/10ps
`include "wl_consts.svh"

module tb_gat_wgt_loader;

  import wl_pkg::*;

  localparam int CLK_PERIOD      = 4;
  localparam int WATCHDOG_CYCLES = 20 * 60;
  localparam int LAST_ADDR       = `WL_TOTAL_WORDS - 1;

  logic                                         clk;
  logic                                         rst_n;
  logic                                         sched_vld_i;
  logic                                         sched_rdy_o;
  word_addr_t                                   wgt_addr_o;
  data_t                                        wgt_data_i;
  bank_row_t [`WL_FEAT_OUT-1:0]                 mult_wgt_addr_i;
  data_t [`WL_FEAT_OUT-1:0]                     mult_wgt_dout_o;
  data_t [`WL_A1_WORDS-1:0]                     a_conv1_o;
  data_t [`WL_FEAT_FINAL-1:0][`WL_FEAT_OUT-1:0] wgt_o;
  data_t [`WL_A2_WORDS-1:0]                     a_conv2_o;
  logic                                         load_we;
  word_addr_t                                   load_addr;
  data_t                                        load_data;

  // Reference copy of the weight image
  data_t       image [`WL_TOTAL_WORDS];
  logic [31:0] lcg_state;
  int          checks;
  int          errors;
  int          reported_errors;

  gat_wgt_loader u_gat_wgt_loader (.*);

  wgt_mem_model u_wgt_mem (
    .clk         (clk),
    .load_we_i   (load_we),
    .load_addr_i (load_addr),
    .load_data_i (load_data),
    .rd_addr_i   (wgt_addr_o),
    .rd_data_o   (wgt_data_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_data(input data_t got, input data_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic check_rdy(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input word_addr_t got, input word_addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic report_result(input string name);
    $display("%-22s %0d errors", name, errors - reported_errors);
    reported_errors = errors;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n       <= 1'b0;
    sched_vld_i <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // Fresh image from the LCG, written through the model's load port
  task automatic load_image();
    for (int i = 0; i < `WL_TOTAL_WORDS; i++) begin
      lcg_state = lcg_next(lcg_state);
      image[i]  = lcg_state[23:16];
      @(posedge clk);
      load_we   <= 1'b1;
      load_addr <= word_addr_t'(i);
      load_data <= image[i];
    end
    @(posedge clk);
    load_we <= 1'b0;
  endtask

  task automatic attn_vectors();
    for (int k = 0; k < `WL_A1_WORDS; k++) begin
      check_data(a_conv1_o[k], image[`WL_A1_BASE + k], $sformatf("a_conv1 entry %0d", k));
    end
    for (int k = 0; k < `WL_A2_WORDS; k++) begin
      check_data(a_conv2_o[k], image[`WL_A2_BASE + k], $sformatf("a_conv2 entry %0d", k));
    end
  endtask

  // Word k of the segment sits at class k mod 3, hidden row k / 3
  task automatic conv2_matrix();
    for (int c = 0; c < `WL_FEAT_FINAL; c++) begin
      for (int h = 0; h < `WL_FEAT_OUT; h++) begin
        check_data(wgt_o[c][h], image[`WL_W2_BASE + h * `WL_FEAT_FINAL + c],
                   $sformatf("wgt class %0d hidden %0d", c, h));
      end
    end
  endtask

  // Each bank gets a different row so the read ports are told apart
  task automatic conv1_banks();
    for (int r = 0; r < `WL_FEAT_IN; r++) begin
      @(posedge clk);
      for (int b = 0; b < `WL_FEAT_OUT; b++) begin
        mult_wgt_addr_i[b] <= bank_row_t'((r + b) % `WL_FEAT_IN);
      end
      // One edge of read latency
      @(posedge clk);
      @(negedge clk);
      for (int b = 0; b < `WL_FEAT_OUT; b++) begin
        check_data(mult_wgt_dout_o[b],
                   image[((r + b) % `WL_FEAT_IN) * `WL_FEAT_OUT + b],
                   $sformatf("bank %0d row %0d", b, (r + b) % `WL_FEAT_IN));
      end
    end
  endtask

  task automatic reset_state();
    @(negedge clk);
    check_rdy(sched_rdy_o, 1'b0, "ready after reset");
    check_addr(wgt_addr_o, '0, "address after reset");
    for (int k = 0; k < `WL_A1_WORDS; k++) begin
      check_data(a_conv1_o[k], '0, $sformatf("a_conv1 entry %0d after reset", k));
    end
    for (int k = 0; k < `WL_A2_WORDS; k++) begin
      check_data(a_conv2_o[k], '0, $sformatf("a_conv2 entry %0d after reset", k));
    end
    for (int c = 0; c < `WL_FEAT_FINAL; c++) begin
      for (int h = 0; h < `WL_FEAT_OUT; h++) begin
        check_data(wgt_o[c][h], '0, $sformatf("wgt class %0d hidden %0d after reset", c, h));
      end
    end
  endtask

  task automatic continuous_load();
    int cyc;
    cyc = 0;
    @(posedge clk);
    sched_vld_i <= 1'b1;
    @(negedge clk);
    while (wgt_addr_o != word_addr_t'(LAST_ADDR) && cyc < 2 * `WL_TOTAL_WORDS) begin
      @(negedge clk);
      cyc++;
    end
    if (wgt_addr_o != word_addr_t'(LAST_ADDR)) begin
      errors++;
      $display("Last weight address was not issued within %0d cycles", cyc);
    end
    // Last word is written two edges after its address, ready follows one edge later
    for (int n = 1; n <= 3; n++) begin
      @(negedge clk);
      check_rdy(sched_rdy_o, logic'(n == 3),
                $sformatf("ready %0d cycles after last address", n));
    end
    attn_vectors();
  endtask

  task automatic paused_load();
    int         cyc;
    logic       vld_seen;
    word_addr_t hold_addr;
    cyc = 0;
    apply_reset();
    load_image();
    vld_seen  = 1'b0;
    hold_addr = '0;
    while (!sched_rdy_o && cyc < 6 * `WL_TOTAL_WORDS) begin
      @(posedge clk);
      lcg_state = lcg_next(lcg_state);
      sched_vld_i <= lcg_state[28];
      @(negedge clk);
      // An edge that saw valid low must leave the address alone
      if (!vld_seen) begin
        check_addr(wgt_addr_o, hold_addr, "address during pause");
      end
      hold_addr = wgt_addr_o;
      vld_seen  = sched_vld_i;
      cyc++;
    end
    if (!sched_rdy_o) begin
      errors++;
      $display("Ready never rose during the paused load");
    end
    // Everything has to be in place in the first cycle with ready high
    attn_vectors();
    conv2_matrix();
    @(posedge clk);
    sched_vld_i <= 1'b1;
    repeat (8) begin
      @(negedge clk);
      check_addr(wgt_addr_o, word_addr_t'(LAST_ADDR), "address after done");
      check_rdy(sched_rdy_o, 1'b1, "ready after done");
    end
    attn_vectors();
    conv2_matrix();
    conv1_banks();
  endtask

  initial begin
    rst_n           = 1'b0;
    sched_vld_i     = 1'b0;
    mult_wgt_addr_i = '0;
    load_we         = 1'b0;
    load_addr       = '0;
    load_data       = '0;
    lcg_state       = 32'h39e15982;
    checks          = 0;
    errors          = 0;
    reported_errors = 0;
    apply_reset();
    reset_state();
    report_result("reset state");
    load_image();
    continuous_load();
    report_result("continuous load");
    conv2_matrix();
    report_result("second-layer matrix");
    conv1_banks();
    report_result("first-layer banks");
    paused_load();
    report_result("paused load");
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+rtl
rtl/wl_pkg.sv
rtl/wgt_fetch_seq.sv
rtl/conv1_wgt_banks.sv
rtl/attn_vec_reg.sv
rtl/conv2_wgt_reg.sv
rtl/gat_wgt_loader.sv
verif/wgt_mem_model.sv
verif/tb_gat_wgt_loader.sv

// File: Bender.yml
package:
  name: gat_wgt_loader

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/wl_pkg.sv
      - rtl/wgt_fetch_seq.sv
      - rtl/conv1_wgt_banks.sv
      - rtl/attn_vec_reg.sv
      - rtl/conv2_wgt_reg.sv
      - rtl/gat_wgt_loader.sv
  - target: test
    files:
      - verif/wgt_mem_model.sv
      - verif/tb_gat_wgt_loader.sv
